/* rtl/camera_pkg.sv */
package camera_pkg;

  // raster coordinates, wide enough for a 1280x720 sensor
  typedef logic [10:0] x_t;
  typedef logic [9:0]  y_t;

  // column and row tag carried with every pixel
  typedef struct packed {
    x_t x;
    y_t y;
  } pixel_loc_t;

  // camera output format, first byte on the bus holds r and the top of g
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // raw parallel bus as it arrives at the pins
  typedef struct packed {
    logic [7:0] data;
    logic       pclk;
    logic       hsync;
    logic       vsync;
  } cam_bus_t;

  // one reconstructed pixel, last marks the bottom right corner
  typedef struct packed {
    logic       valid;
    pixel_loc_t loc;
    rgb565_t    rgb;
    logic       last;
  } pixel_beat_t;

endpackage

/* rtl/tracking_pkg.sv */
package tracking_pkg;

  // inclusive background window in the cr/cb plane
  typedef struct packed {
    logic [7:0] cr_lo;
    logic [7:0] cr_hi;
    logic [7:0] cb_lo;
    logic [7:0] cb_hi;
  } chroma_window_t;

  typedef struct packed {
    logic                  valid;
    camera_pkg::pixel_loc_t loc;
    logic [7:0]            cr;
    logic [7:0]            cb;
    logic                  last;
  } chroma_beat_t;

  // is_player is high for anything outside the window
  typedef struct packed {
    logic                  valid;
    camera_pkg::pixel_loc_t loc;
    logic                  is_player;
    logic                  last;
  } mask_beat_t;

  typedef struct packed {
    camera_pkg::x_t x;
    camera_pkg::y_t y;
  } centroid_t;

  // bt.601 style chroma weights, scaled by 256
  localparam logic signed [8:0] CR_COEF_R = 9'sd112;
  localparam logic signed [8:0] CR_COEF_G = -9'sd94;
  localparam logic signed [8:0] CR_COEF_B = -9'sd18;
  localparam logic signed [8:0] CB_COEF_R = -9'sd38;
  localparam logic signed [8:0] CB_COEF_G = -9'sd74;
  localparam logic signed [8:0] CB_COEF_B = 9'sd112;
  localparam logic [7:0]        CHROMA_OFFSET = 8'd128;

  // pixel count of a full frame plus one, so an all-player frame fits
  function automatic int count_width(int width, int height);
    return $clog2(width * height + 1);
  endfunction

  // bound on a coordinate sum, every pixel at the largest coordinate
  function automatic int sum_width(int width, int height, int span);
    return $clog2(width * height * span + 1);
  endfunction

endpackage

/* rtl/pixel_reconstruct.sv */
`timescale 1ns/1ns

module pixel_reconstruct #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  camera_pkg::cam_bus_t    cam_bus_i,
  output camera_pkg::pixel_beat_t pixel_o
);

  import camera_pkg::*;

  // ====================================================================
  // two flop synchronizer and edge detection
  // ====================================================================

  cam_bus_t sync_a;
  cam_bus_t sync_b;
  // previous synchronized pclk and hsync, only these need edges
  logic     pclk_d;
  logic     hsync_d;

  always_ff @(posedge clk_camera) begin
    sync_a  <= cam_bus_i;
    sync_b  <= sync_a;
    pclk_d  <= sync_b.pclk;
    hsync_d <= sync_b.hsync;
  end

  // capture stage, one cycle after the synchronizer
  logic       take_q;
  logic       hs_fall_q;
  logic       vs_q;
  logic [7:0] data_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      take_q    <= 1'b0;
      hs_fall_q <= 1'b0;
      vs_q      <= 1'b0;
    end else begin
      // a byte counts only on a pclk rise inside the active line
      take_q    <= sync_b.pclk & ~pclk_d & sync_b.hsync;
      hs_fall_q <= hsync_d & ~sync_b.hsync;
      vs_q      <= sync_b.vsync;
    end
  end

  always_ff @(posedge clk_camera) begin
    data_q <= sync_b.data;
  end

  // ====================================================================
  // byte pairing and raster counters
  // ====================================================================

  logic       phase;
  logic [7:0] upper_byte;
  x_t         col;
  y_t         row;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase         <= 1'b0;
      col           <= '0;
      row           <= '0;
      pixel_o.valid <= 1'b0;
      pixel_o.last  <= 1'b0;
    end else begin
      pixel_o.valid <= 1'b0;
      if (vs_q) begin
        // frame blanking, start over at the top left
        phase <= 1'b0;
        col   <= '0;
        row   <= '0;
      end else if (hs_fall_q) begin
        phase <= 1'b0;
        col   <= '0;
        row   <= row + 1'b1;
      end else if (take_q) begin
        if (!phase) begin
          // first byte is the upper half of the word
          upper_byte <= data_q;
          phase      <= 1'b1;
        end else begin
          phase         <= 1'b0;
          pixel_o.valid <= 1'b1;
          pixel_o.rgb   <= {upper_byte, data_q};
          pixel_o.loc   <= '{x: col, y: row};
          pixel_o.last  <= (col == x_t'(FRAME_WIDTH - 1)) &&
                           (row == y_t'(FRAME_HEIGHT - 1));
          // hold at the right edge if a line runs long
          if (col != x_t'(FRAME_WIDTH - 1)) begin
            col <= col + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* rtl/chroma_convert.sv */
`timescale 1ns/1ns

module chroma_convert (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  camera_pkg::pixel_beat_t   pixel_i,
  output tracking_pkg::chroma_beat_t chroma_o
);

  import camera_pkg::*;
  import tracking_pkg::*;

  // tags that ride along with the arithmetic
  typedef struct packed {
    logic       valid;
    pixel_loc_t loc;
    logic       last;
  } tag_t;

  tag_t s1_tag;
  tag_t s2_tag;

  // stage 1 widens every channel to 8 bits
  logic [7:0] s1_r;
  logic [7:0] s1_g;
  logic [7:0] s1_b;

  // stage 2 products and sums, 9x9 signed never needs more than 18 bits
  logic signed [17:0] cr_sum;
  logic signed [17:0] cb_sum;

  // floored divide by 256
  logic signed [17:0] cr_fl;
  logic signed [17:0] cb_fl;

  always_comb begin
    cr_fl = cr_sum >>> 8;
    cb_fl = cb_sum >>> 8;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      s1_tag.valid   <= 1'b0;
      s2_tag.valid   <= 1'b0;
      chroma_o.valid <= 1'b0;
    end else begin
      s1_tag.valid   <= pixel_i.valid;
      s2_tag.valid   <= s1_tag.valid;
      chroma_o.valid <= s2_tag.valid;
    end
  end

  always_ff @(posedge clk_camera) begin
    s1_tag.loc  <= pixel_i.loc;
    s1_tag.last <= pixel_i.last;
    s1_r        <= {pixel_i.rgb.r, 3'b000};
    s1_g        <= {pixel_i.rgb.g, 2'b00};
    s1_b        <= {pixel_i.rgb.b, 3'b000};

    s2_tag.loc  <= s1_tag.loc;
    s2_tag.last <= s1_tag.last;
    cr_sum      <= $signed({1'b0, s1_r}) * CR_COEF_R +
                   $signed({1'b0, s1_g}) * CR_COEF_G +
                   $signed({1'b0, s1_b}) * CR_COEF_B;
    cb_sum      <= $signed({1'b0, s1_r}) * CB_COEF_R +
                   $signed({1'b0, s1_g}) * CB_COEF_G +
                   $signed({1'b0, s1_b}) * CB_COEF_B;

    // stage 3 recentres around 128, wraps modulo 256
    chroma_o.loc  <= s2_tag.loc;
    chroma_o.last <= s2_tag.last;
    chroma_o.cr   <= cr_fl[7:0] + CHROMA_OFFSET;
    chroma_o.cb   <= cb_fl[7:0] + CHROMA_OFFSET;
  end

endmodule

/* rtl/chroma_keyer.sv */
`timescale 1ns/1ns

module chroma_keyer (
  input  logic                        clk_camera,
  input  logic                        recent_reset,
  input  tracking_pkg::chroma_beat_t  chroma_i,
  input  tracking_pkg::chroma_window_t window_i,
  output tracking_pkg::mask_beat_t    mask_o
);

  import tracking_pkg::*;

  logic cr_in_window;
  logic cb_in_window;
  logic is_background;

  // both bounds inclusive
  always_comb begin
    cr_in_window  = (chroma_i.cr >= window_i.cr_lo) && (chroma_i.cr <= window_i.cr_hi);
    cb_in_window  = (chroma_i.cb >= window_i.cb_lo) && (chroma_i.cb <= window_i.cb_hi);
    // background needs both channels inside the window
    is_background = cr_in_window & cb_in_window;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mask_o.valid <= 1'b0;
    end else begin
      mask_o.valid <= chroma_i.valid;
    end
  end

  always_ff @(posedge clk_camera) begin
    mask_o.loc       <= chroma_i.loc;
    mask_o.last      <= chroma_i.last;
    mask_o.is_player <= ~is_background;
  end

endmodule

/* rtl/centroid_accumulator.sv */
`timescale 1ns/1ns

module centroid_accumulator #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720,
  localparam int SX_W  = tracking_pkg::sum_width(FRAME_WIDTH, FRAME_HEIGHT, FRAME_WIDTH),
  localparam int SY_W  = tracking_pkg::sum_width(FRAME_WIDTH, FRAME_HEIGHT, FRAME_HEIGHT),
  localparam int CNT_W = tracking_pkg::count_width(FRAME_WIDTH, FRAME_HEIGHT)
) (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  tracking_pkg::mask_beat_t mask_i,
  output logic                     frame_done_o,
  output logic [SX_W-1:0]          sum_x_o,
  output logic [SY_W-1:0]          sum_y_o,
  output logic [CNT_W-1:0]         count_o
);

  // running totals for the frame in progress
  logic [SX_W-1:0]  run_x;
  logic [SY_W-1:0]  run_y;
  logic [CNT_W-1:0] run_n;

  // totals including the current beat
  logic [SX_W-1:0]  next_x;
  logic [SY_W-1:0]  next_y;
  logic [CNT_W-1:0] next_n;

  always_comb begin
    next_x = run_x;
    next_y = run_y;
    next_n = run_n;
    // background pixels add nothing
    if (mask_i.valid && mask_i.is_player) begin
      next_x = run_x + SX_W'(mask_i.loc.x);
      next_y = run_y + SY_W'(mask_i.loc.y);
      next_n = run_n + 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      run_x        <= '0;
      run_y        <= '0;
      run_n        <= '0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= 1'b0;
      if (mask_i.valid && mask_i.last) begin
        // frame complete, next frame starts from zero
        run_x        <= '0;
        run_y        <= '0;
        run_n        <= '0;
        frame_done_o <= 1'b1;
      end else begin
        run_x <= next_x;
        run_y <= next_y;
        run_n <= next_n;
      end
    end
  end

  // snapshot held for the divider while the next frame accumulates
  always_ff @(posedge clk_camera) begin
    if (mask_i.valid && mask_i.last) begin
      sum_x_o <= next_x;
      sum_y_o <= next_y;
      count_o <= next_n;
    end
  end

endmodule

/* rtl/centroid_divider.sv */
`timescale 1ns/1ns

module centroid_divider #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720,
  localparam int SX_W  = tracking_pkg::sum_width(FRAME_WIDTH, FRAME_HEIGHT, FRAME_WIDTH),
  localparam int SY_W  = tracking_pkg::sum_width(FRAME_WIDTH, FRAME_HEIGHT, FRAME_HEIGHT),
  localparam int CNT_W = tracking_pkg::count_width(FRAME_WIDTH, FRAME_HEIGHT)
) (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic                    frame_done_i,
  input  logic [SX_W-1:0]         sum_x_i,
  input  logic [SY_W-1:0]         sum_y_i,
  input  logic [CNT_W-1:0]        count_i,
  output tracking_pkg::centroid_t com_o,
  output logic                    com_valid_o
);

  import camera_pkg::*;

  // both quotients run in lockstep over the wider dividend
  localparam int DW = (SX_W > SY_W) ? SX_W : SY_W;
  localparam int STEP_W = $clog2(DW + 1);

  typedef enum logic [1:0] {IDLE, DIVIDE, FINISH} state_t;

  state_t            state;
  logic [STEP_W-1:0] step;
  logic [CNT_W-1:0]  divisor;
  // dividend shifts out the top while quotient bits enter the bottom
  logic [DW-1:0]     qx;
  logic [DW-1:0]     qy;
  logic [CNT_W-1:0]  rx;
  logic [CNT_W-1:0]  ry;
  logic [CNT_W:0]    step_x;
  logic [CNT_W:0]    step_y;

  // one restoring step, returns {remainder, quotient bit}
  function automatic logic [CNT_W:0] restore_step(logic [CNT_W-1:0] rem, logic bit_in,
                                                  logic [CNT_W-1:0] dvs);
    logic [CNT_W:0] trial;
    logic [CNT_W:0] diff;
    trial = {rem, bit_in};
    diff  = trial - {1'b0, dvs};
    if (trial >= {1'b0, dvs}) begin
      return {diff[CNT_W-1:0], 1'b1};
    end
    return {trial[CNT_W-1:0], 1'b0};
  endfunction

  always_comb begin
    step_x = restore_step(rx, qx[DW-1], divisor);
    step_y = restore_step(ry, qy[DW-1], divisor);
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state       <= IDLE;
      step        <= '0;
      com_o       <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= 1'b0;
      case (state)
        IDLE: begin
          // empty frame leaves the previous centroid in place
          if (frame_done_i && (count_i != '0)) begin
            state <= DIVIDE;
            step  <= STEP_W'(DW);
          end
        end
        DIVIDE: begin
          step <= step - 1'b1;
          if (step == STEP_W'(1)) begin
            state <= FINISH;
          end
        end
        default: begin
          // quotients are floored means, they always fit a coordinate
          com_o.x     <= x_t'(qx);
          com_o.y     <= y_t'(qy);
          com_valid_o <= 1'b1;
          state       <= IDLE;
        end
      endcase
    end
  end

  // datapath registers, loaded on a new frame and shifted while dividing
  always_ff @(posedge clk_camera) begin
    if (state == IDLE) begin
      qx      <= DW'(sum_x_i);
      qy      <= DW'(sum_y_i);
      rx      <= '0;
      ry      <= '0;
      divisor <= count_i;
    end else if (state == DIVIDE) begin
      qx <= {qx[DW-2:0], step_x[0]};
      qy <= {qy[DW-2:0], step_y[0]};
      rx <= step_x[CNT_W:1];
      ry <= step_y[CNT_W:1];
    end
  end

endmodule

/* rtl/camera_tracker_top.sv */
`timescale 1ns/1ns

module camera_tracker_top #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  logic                         clk_camera,
  input  logic                         recent_reset,
  input  camera_pkg::cam_bus_t         cam_bus_i,
  input  tracking_pkg::chroma_window_t window_i,
  output tracking_pkg::mask_beat_t     mask_o,
  output tracking_pkg::centroid_t      com_o,
  output logic                         com_valid_o
);

  import camera_pkg::*;
  import tracking_pkg::*;

  localparam int SX_W  = sum_width(FRAME_WIDTH, FRAME_HEIGHT, FRAME_WIDTH);
  localparam int SY_W  = sum_width(FRAME_WIDTH, FRAME_HEIGHT, FRAME_HEIGHT);
  localparam int CNT_W = count_width(FRAME_WIDTH, FRAME_HEIGHT);

  // ====================================================================
  // pixel path, camera pins to player mask
  // ====================================================================

  pixel_beat_t  pixel;
  chroma_beat_t chroma;

  pixel_reconstruct #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) i_pixel_reconstruct (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .cam_bus_i   (cam_bus_i),
    .pixel_o     (pixel)
  );

  chroma_convert i_chroma_convert (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .pixel_i     (pixel),
    .chroma_o    (chroma)
  );

  // mask_o is also the accumulator input
  chroma_keyer i_chroma_keyer (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .chroma_i    (chroma),
    .window_i    (window_i),
    .mask_o      (mask_o)
  );

  // ====================================================================
  // per frame centroid
  // ====================================================================

  logic             frame_done;
  logic [SX_W-1:0]  sum_x;
  logic [SY_W-1:0]  sum_y;
  logic [CNT_W-1:0] count;

  centroid_accumulator #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) i_centroid_accumulator (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .mask_i      (mask_o),
    .frame_done_o(frame_done),
    .sum_x_o     (sum_x),
    .sum_y_o     (sum_y),
    .count_o     (count)
  );

  centroid_divider #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) i_centroid_divider (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .frame_done_i(frame_done),
    .sum_x_i     (sum_x),
    .sum_y_i     (sum_y),
    .count_i     (count),
    .com_o       (com_o),
    .com_valid_o (com_valid_o)
  );

endmodule

/* verif/tb_camera_tracker.sv */
`timescale 1ns/1ns

module tb_camera_tracker;

  import camera_pkg::*;
  import tracking_pkg::*;

  localparam int FRAME_W      = 8;
  localparam int FRAME_H      = 4;
  localparam int PIXELS       = FRAME_W * FRAME_H;
  localparam int NUM_FRAMES   = 4;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  // window word, one word per pixel, expected centroid word
  localparam int FRAME_WORDS  = PIXELS + 2;
  // worst case frame, every random gap at its longest
  localparam int FRAME_CYCLES = 24 + FRAME_H * (4 + FRAME_W * 20 + 16);
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + 500) * CLK_PERIOD;

  logic           clk_camera;
  logic           recent_reset;
  cam_bus_t       cam_bus;
  chroma_window_t window;
  mask_beat_t     mask;
  centroid_t      com;
  logic           com_valid;

  logic [31:0] pattern_mem [0:NUM_FRAMES*FRAME_WORDS-1];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  // ====================================================================
  // reference state, advanced by the output monitor
  // ====================================================================

  int          beat_frame;
  int          beat_index;
  int          beat_total;
  int          sum_x;
  int          sum_y;
  int          player_count;
  // last centroid com_o should be holding
  logic [31:0] model_com;
  // centroids owed by the divider, oldest first
  logic [31:0] pending_com [$];

  camera_tracker_top #(
    .FRAME_WIDTH (FRAME_W),
    .FRAME_HEIGHT(FRAME_H)
  ) i_dut (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .cam_bus_i   (cam_bus),
    .window_i    (window),
    .mask_o      (mask),
    .com_o       (com),
    .com_valid_o (com_valid)
  );

  initial begin : clock_gen
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // chroma key straight from the conversion rules, floor shift and wrap
  function automatic logic player_model(logic [15:0] rgb, logic [31:0] win);
    int   r8;
    int   g8;
    int   b8;
    int   cr;
    int   cb;
    logic background;
    r8 = int'(rgb[15:11]) * 8;
    g8 = int'(rgb[10:5]) * 4;
    b8 = int'(rgb[4:0]) * 8;
    cr = (((112 * r8 - 94 * g8 - 18 * b8) >>> 8) + 128) & 255;
    cb = (((-38 * r8 - 74 * g8 + 112 * b8) >>> 8) + 128) & 255;
    // window bounds inclusive, cr in the top half of the word
    background = (cr >= int'(win[31:24])) && (cr <= int'(win[23:16])) &&
                 (cb >= int'(win[15:8])) && (cb <= int'(win[7:0]));
    return !background;
  endfunction

  // floored means packed like com_o
  function automatic logic [31:0] pack_centroid(int sx, int sy, int n);
    return 32'({x_t'(sx / n), y_t'(sy / n)});
  endfunction

  // file keeps x in the upper half and y in the lower half
  function automatic logic [31:0] file_centroid(logic [31:0] word);
    return 32'({x_t'(word[31:16]), y_t'(word[15:0])});
  endfunction

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  // cross check the file's expected centroids against the model
  task automatic verify_patterns();
    int          base;
    int          n;
    int          sx;
    int          sy;
    logic [31:0] word;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      base = f * FRAME_WORDS;
      n    = 0;
      sx   = 0;
      sy   = 0;
      for (int i = 0; i < PIXELS; i++) begin
        if (player_model(pattern_mem[base + 1 + i][15:0], pattern_mem[base])) begin
          n++;
          sx += i % FRAME_W;
          sy += i / FRAME_W;
        end
      end
      word = pattern_mem[base + FRAME_WORDS - 1];
      if (word == 32'hffffffff) begin
        if (n != 0) begin
          report_problem($sformatf("pattern frame %0d expects no centroid but has players", f));
        end
      end else if (n == 0) begin
        report_problem($sformatf("pattern frame %0d expects a centroid but has no players", f));
      end else begin
        compare_value("pattern centroid", file_centroid(word), pack_centroid(sx, sy, n));
      end
    end
  endtask

  task automatic check_reset_outputs();
    compare_value("mask_o.valid", 32'(mask.valid), 32'd0);
    compare_value("com_valid_o", 32'(com_valid), 32'd0);
    compare_value("com_o", 32'(com), 32'd0);
  endtask

  // end of a frame in the mask stream
  task automatic close_frame();
    // the previous frame's centroid is due before this frame ends
    if (pending_com.size() != 0) begin
      report_problem($sformatf("no com_valid_o pulse for the frame before frame %0d", beat_frame));
      pending_com.delete();
    end
    compare_value("com_o", 32'(com), model_com);
    if (player_count != 0) begin
      pending_com.push_back(pack_centroid(sum_x, sum_y, player_count));
    end
    sum_x        = 0;
    sum_y        = 0;
    player_count = 0;
    beat_index   = 0;
    beat_frame++;
  endtask

  task automatic check_beat();
    int   base;
    logic exp_player;
    if (beat_frame >= NUM_FRAMES) begin
      report_problem("mask beat arrived after the last frame had completed");
    end else begin
      base       = beat_frame * FRAME_WORDS;
      exp_player = player_model(pattern_mem[base + 1 + beat_index][15:0], pattern_mem[base]);
      // raster order, one beat per pixel
      compare_value("mask_o.loc.x", 32'(mask.loc.x), beat_index % FRAME_W);
      compare_value("mask_o.loc.y", 32'(mask.loc.y), beat_index / FRAME_W);
      compare_value("mask_o.is_player", 32'(mask.is_player), 32'(exp_player));
      compare_value("mask_o.last", 32'(mask.last), 32'(beat_index == PIXELS - 1));
      if (exp_player) begin
        sum_x += beat_index % FRAME_W;
        sum_y += beat_index / FRAME_W;
        player_count++;
      end
      beat_total++;
      if (beat_index == PIXELS - 1) begin
        close_frame();
      end else begin
        beat_index++;
      end
    end
  endtask

  task automatic check_centroid();
    if (pending_com.size() == 0) begin
      report_problem("com_valid_o pulsed with no finished frame waiting for a centroid");
    end else begin
      model_com = pending_com.pop_front();
      compare_value("com_o", 32'(com), model_com);
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  initial begin : output_monitor
    forever begin
      @(negedge clk_camera);
      if (recent_reset) begin
        check_reset_outputs();
      end else begin
        if (com_valid === 1'b1) begin
          check_centroid();
        end
        if (mask.valid === 1'b1) begin
          check_beat();
        end
      end
    end
  end

  // ====================================================================
  // camera bus stimulus
  // ====================================================================

  task automatic hold_bus(logic [7:0] data, logic pclk, logic hsync, logic vsync, int cycles);
    repeat (cycles) begin
      @(posedge clk_camera);
      cam_bus <= '{data: data, pclk: pclk, hsync: hsync, vsync: vsync};
    end
  endtask

  // data settles while pclk is low, sampled on the rise
  task automatic send_byte(logic [7:0] data);
    hold_bus(data, 1'b0, 1'b1, 1'b0, 2);
    hold_bus(data, 1'b1, 1'b1, 1'b0, 2);
  endtask

  // 0 to 3 idle pclk periods, pclk held low so no byte is taken
  task automatic idle_periods(logic hsync);
    int gap;
    gap = int'(next_random() >> 16) & 3;
    hold_bus(8'h00, 1'b0, hsync, 1'b0, 4 * gap);
  endtask

  task automatic send_frame(int f);
    int          base;
    logic [15:0] pix;
    base = f * FRAME_WORDS;
    // vertical blanking, long enough for the last frame to leave the keyer
    hold_bus(8'h00, 1'b0, 1'b0, 1'b1, 12);
    window <= pattern_mem[base];
    hold_bus(8'h00, 1'b0, 1'b0, 1'b1, 8);
    hold_bus(8'h00, 1'b0, 1'b0, 1'b0, 4);
    for (int y = 0; y < FRAME_H; y++) begin
      hold_bus(8'h00, 1'b0, 1'b1, 1'b0, 4);
      for (int x = 0; x < FRAME_W; x++) begin
        pix = pattern_mem[base + 1 + y * FRAME_W + x][15:0];
        idle_periods(1'b1);
        // upper byte first
        send_byte(pix[15:8]);
        send_byte(pix[7:0]);
      end
      // hsync falling edge advances the row
      hold_bus(8'h00, 1'b0, 1'b0, 1'b0, 4);
      idle_periods(1'b0);
    end
  endtask

  initial begin : main_sequence
    int drain;
    errors       = 0;
    checks       = 0;
    lcg_state    = 32'hd367;
    beat_frame   = 0;
    beat_index   = 0;
    beat_total   = 0;
    sum_x        = 0;
    sum_y        = 0;
    player_count = 0;
    model_com    = '0;
    recent_reset <= 1'b1;
    cam_bus      <= '{data: 8'h00, pclk: 1'b0, hsync: 1'b0, vsync: 1'b1};
    window       <= '0;
    $readmemh("verif/tracker_patterns.txt", pattern_mem);
    verify_patterns();

    repeat (RESET_CYCLES) @(posedge clk_camera);
    recent_reset <= 1'b0;
    // bus still blanked, outputs must stay quiet just after reset
    repeat (4) begin
      @(negedge clk_camera);
      check_reset_outputs();
    end

    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(f);
    end
    hold_bus(8'h00, 1'b0, 1'b0, 1'b1, 12);

    // wait for the last beats and the last centroid
    drain = 0;
    while ((beat_total < NUM_FRAMES * PIXELS || pending_com.size() != 0) && drain < 200) begin
      @(negedge clk_camera);
      drain++;
    end
    if (beat_total < NUM_FRAMES * PIXELS || pending_com.size() != 0) begin
      report_problem("mask beats or the last centroid never arrived");
    end
    // quiet stretch so surplus beats or pulses show up
    repeat (50) @(negedge clk_camera);
    compare_value("mask beat count", beat_total, NUM_FRAMES * PIXELS);
    compare_value("com_o", 32'(com), model_com);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verif/tracker_patterns.txt */
// per frame: window {cr_lo cr_hi cb_lo cb_hi}, then 4 rows of 8 rgb565 pixels,
// then expected centroid {x[31:16] y[15:0]}, ffffffff when no centroid is expected
10402050
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
07E0 07E0 F800 F800 07E0 07E0 07E0 07E0
07E0 07E0 F800 F800 F800 07E0 07E0 07E0
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
00020001
10402050
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
ffffffff
10402050
07E0 07E0 07E0 07E0 07E0 07E0 001F 001F
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
FFFF 07E0 07E0 07E0 07E0 07E0 07E0 001F
00050001
70907090
0000 07E0 0000 FFFF 0000 0000 0000 0000
0000 07E0 0000 0000 FFFF 0000 0000 0000
0000 0000 0000 0000 0000 07E0 0000 0000
0000 0000 0000 0000 0000 0000 F800 0000
00030001

/* sources.f */
rtl/camera_pkg.sv
rtl/tracking_pkg.sv
rtl/pixel_reconstruct.sv
rtl/chroma_convert.sv
rtl/chroma_keyer.sv
rtl/centroid_accumulator.sv
rtl/centroid_divider.sv
rtl/camera_tracker_top.sv
verif/tb_camera_tracker.sv

/* Makefile */
# Verilator simulation of the camera tracker
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_camera_tracker
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
